// ==== source/alu_pipe.sv ====
// Single-cycle ALU pipe
// Computes the integer micro-ops and holds the result
// in a register until the arbiter grants it
`default_nettype none

module alu_pipe
  import tinyrv1_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  issue_if.pipe      issue,
  complete_if.source done
);

  logic                     res_val;
  logic [xlen-1:0]          res_data;
  logic [reg_addr_bits-1:0] res_waddr;
  logic [xlen-1:0]          alu_out;
  logic                     issue_xfer;

  // Accept when empty or the held result leaves this cycle
  assign issue.rdy  = !res_val || done.rdy;
  assign issue_xfer = issue.val & issue.rdy;

  always_comb begin
    case (issue.uop)
      uop_add: alu_out = issue.op1 + issue.op2;
      uop_sub: alu_out = issue.op1 - issue.op2;
      uop_and: alu_out = issue.op1 & issue.op2;
      uop_or:  alu_out = issue.op1 | issue.op2;
      uop_xor: alu_out = issue.op1 ^ issue.op2;
      // Signed compare
      uop_slt: alu_out = {{(xlen-1){1'b0}}, $signed(issue.op1) < $signed(issue.op2)};
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_val <= 1'b0;
    end else if (issue_xfer) begin
      res_val <= 1'b1;
    end else if (done.rdy) begin
      res_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_xfer) begin
      res_data  <= alu_out;
      res_waddr <= issue.waddr;
    end
  end

  assign done.val   = res_val;
  assign done.wdata = res_data;
  assign done.waddr = res_waddr;

endmodule

`default_nettype wire

// ==== source/complete_arbiter.sv ====
// Completion arbiter
// Fixed priority, multiplier over ALU, onto the shared
// writeback bus; grants are combinational in the request cycle
`default_nettype none

module complete_arbiter (
  complete_if.sink   alu_done,
  complete_if.sink   mul_done,
  complete_if.source wb
);

  logic mul_grant;
  logic alu_grant;

  // --------------------------------------------------
  // Grant
  // --------------------------------------------------

  // Mul first, its deeper pipe backs up faster
  assign mul_grant = mul_done.val & wb.rdy;
  assign alu_grant = alu_done.val & !mul_done.val & wb.rdy;

  assign mul_done.rdy = mul_grant;
  assign alu_done.rdy = alu_grant;

  // --------------------------------------------------
  // Result mux
  // --------------------------------------------------

  assign wb.val = alu_done.val | mul_done.val;

  always_comb begin
    if (mul_done.val) begin
      wb.waddr = mul_done.waddr;
      wb.wdata = mul_done.wdata;
    end else begin
      wb.waddr = alu_done.waddr;
      wb.wdata = alu_done.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/decode_issue_unit.sv ====
// Decode and issue unit
// One-entry decode register, hazard stall through the scoreboard,
// operand selection and routing to the ALU or multiplier pipe
`default_nettype none

module decode_issue_unit
  import tinyrv1_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  fetch_if.dst     fetch,
  issue_if.issuer  alu,
  issue_if.issuer  mul,
  complete_if.sink wb
);

  logic                     d_val;
  logic [xlen-1:0]          d_inst;
  logic                     fetch_xfer;
  logic                     issue_xfer;
  logic                     issue_ok;
  logic                     discard;
  logic                     illegal;

  rv_uop                    dec_uop;
  pipe_sel                  dec_pipe;
  logic [reg_addr_bits-1:0] dec_raddr0;
  logic [reg_addr_bits-1:0] dec_raddr1;
  logic [reg_addr_bits-1:0] dec_waddr;
  logic                     dec_op2_imm;
  logic [xlen-1:0]          dec_imm;

  logic [xlen-1:0]          rdata0;
  logic [xlen-1:0]          rdata1;
  logic                     busy;
  logic [xlen-1:0]          op2;

  // --------------------------------------------------
  // Decode register
  // --------------------------------------------------

  assign fetch_xfer = fetch.val & fetch.rdy;

  // Free when empty, or when the held entry leaves this cycle
  assign fetch.rdy = !d_val || issue_xfer || discard;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (fetch_xfer) begin
      d_val <= 1'b1;
    end else if (issue_xfer || discard) begin
      d_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      d_inst <= fetch.inst;
    end
  end

  // --------------------------------------------------
  // Decode and operand read
  // --------------------------------------------------

  inst_decoder inst_decoder_inst (
    .inst    (d_inst),
    .uop     (dec_uop),
    .pipe    (dec_pipe),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .op2_imm (dec_op2_imm),
    .imm     (dec_imm)
  );

  regfile_scoreboard regfile_scoreboard_inst (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .wb       (wb),
    .set_addr (dec_waddr),
    .set_val  (issue_xfer),
    .busy     (busy)
  );

  // --------------------------------------------------
  // Issue routing
  // --------------------------------------------------

  assign illegal  = (dec_uop == uop_illegal);
  // Illegal entries drop without waiting on hazards
  assign discard  = d_val & illegal;
  assign issue_ok = d_val & !illegal & !busy;

  // val never looks at rdy
  assign alu.val = issue_ok & (dec_pipe == pipe_alu);
  assign mul.val = issue_ok & (dec_pipe == pipe_mul);

  assign issue_xfer = (alu.val & alu.rdy) | (mul.val & mul.rdy);

  assign op2 = dec_op2_imm ? dec_imm : rdata1;

  // Shared payload, only the selected pipe sees val
  assign alu.uop   = dec_uop;
  assign alu.op1   = rdata0;
  assign alu.op2   = op2;
  assign alu.waddr = dec_waddr;
  assign mul.uop   = dec_uop;
  assign mul.op1   = rdata0;
  assign mul.op2   = op2;
  assign mul.waddr = dec_waddr;

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
// Instruction decoder
// Maps opcode, funct3 and funct7 to a micro-op and target pipe,
// extracts register addresses and builds the I-type immediate
`default_nettype none

module inst_decoder
  import tinyrv1_pkg::*;
(
  input  logic [xlen-1:0]          inst,
  output rv_uop                    uop,
  output pipe_sel                  pipe,
  output logic [reg_addr_bits-1:0] raddr0,
  output logic [reg_addr_bits-1:0] raddr1,
  output logic [reg_addr_bits-1:0] waddr,
  output logic                     op2_imm,
  output logic [xlen-1:0]          imm
);

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [reg_addr_bits-1:0] rd;
  logic                     legal;

  // Raw fields
  assign opcode = inst[opcode_lsb +: 7];
  assign funct3 = inst[funct3_lsb +: 3];
  assign funct7 = inst[funct7_lsb +: 7];
  assign rs1    = inst[rs1_lsb +: reg_addr_bits];
  assign rs2    = inst[rs2_lsb +: reg_addr_bits];
  assign rd     = inst[rd_lsb +: reg_addr_bits];

  // Sign-extended 12-bit I-type immediate
  assign imm = {{(xlen-12){inst[xlen-1]}}, inst[imm_lsb +: 12]};

  always_comb begin
    uop     = uop_illegal;
    op2_imm = 1'b0;
    case (opcode)
      op_reg: begin
        case ({funct7, funct3})
          {f7_base, f3_add}: uop = uop_add;
          {f7_sub,  f3_add}: uop = uop_sub;
          {f7_base, f3_and}: uop = uop_and;
          {f7_base, f3_or }: uop = uop_or;
          {f7_base, f3_xor}: uop = uop_xor;
          {f7_base, f3_slt}: uop = uop_slt;
          {f7_mul,  f3_add}: uop = uop_mul;
          default:           uop = uop_illegal;
        endcase
      end
      op_imm: begin
        op2_imm = 1'b1;
        case (funct3)
          f3_add:  uop = uop_add;
          f3_and:  uop = uop_and;
          f3_or:   uop = uop_or;
          default: uop = uop_illegal;
        endcase
      end
      default: uop = uop_illegal;
    endcase
  end

  assign legal = (uop != uop_illegal);
  assign pipe  = (uop == uop_mul) ? pipe_mul : pipe_alu;

  // Unused sources point at x0 so the scoreboard never stalls on them
  assign raddr0 = legal ? rs1 : '0;
  assign raddr1 = (legal && !op2_imm) ? rs2 : '0;
  assign waddr  = legal ? rd : '0;

endmodule

`default_nettype wire

// ==== source/mul_pipe.sv ====
// Three-stage multiplier pipe
// Operand capture, partial products, final sum; low 32 bits only
// Whole pipe stalls when the last stage holds an ungranted result
`default_nettype none

module mul_pipe
  import tinyrv1_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  issue_if.pipe      issue,
  complete_if.source done
);

  logic [mul_stages-1:0]    stage_val;
  logic                     advance;

  logic [xlen-1:0]          s1_a;
  logic [xlen-1:0]          s1_b;
  logic [reg_addr_bits-1:0] s1_waddr;
  logic [xlen-1:0]          s2_pp_lo;
  logic [half_xlen-1:0]     s2_pp_hi;
  logic [reg_addr_bits-1:0] s2_waddr;
  logic [xlen-1:0]          s3_prod;
  logic [reg_addr_bits-1:0] s3_waddr;

  // Global stall
  assign advance   = !stage_val[mul_stages-1] || done.rdy;
  assign issue.rdy = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_val <= '0;
    end else if (advance) begin
      stage_val <= {stage_val[mul_stages-2:0], issue.val};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_a     <= issue.op1;
      s1_b     <= issue.op2;
      s1_waddr <= issue.waddr;
      // a * b_lo, plus a_lo * b_hi which only matters in the upper half
      s2_pp_lo <= s1_a * s1_b[half_xlen-1:0];
      s2_pp_hi <= s1_a[half_xlen-1:0] * s1_b[xlen-1:half_xlen];
      s2_waddr <= s1_waddr;
      s3_prod  <= s2_pp_lo + {s2_pp_hi, {half_xlen{1'b0}}};
      s3_waddr <= s2_waddr;
    end
  end

  assign done.val   = stage_val[mul_stages-1];
  assign done.wdata = s3_prod;
  assign done.waddr = s3_waddr;

endmodule

`default_nettype wire

// ==== source/regfile_scoreboard.sv ====
// Register file with pending-destination scoreboard
// Two combinational reads, one write from the completion bus,
// one pending bit per register for RAW and WAW stalls
`default_nettype none

module regfile_scoreboard
  import tinyrv1_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [reg_addr_bits-1:0] raddr0,
  input  logic [reg_addr_bits-1:0] raddr1,
  output logic [xlen-1:0]          rdata0,
  output logic [xlen-1:0]          rdata1,
  complete_if.sink                 wb,
  input  logic [reg_addr_bits-1:0] set_addr,
  input  logic                     set_val,
  output logic                     busy
);

  logic [xlen-1:0]     regs [num_regs];
  logic [num_regs-1:0] pending;

  // Completion bus is never back-pressured
  assign wb.rdy = 1'b1;

  // --------------------------------------------------
  // Register array
  // --------------------------------------------------

  // x0 never written
  always_ff @(posedge clk) begin
    if (wb.val && (wb.waddr != '0)) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  // No bypass, same-cycle write seen next cycle
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb.val) begin
        pending[wb.waddr] <= 1'b0;
      end
      // Set after clear, issue to a just-completing reg is stalled anyway
      if (set_val && (set_addr != '0)) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  // Either source (RAW) or the destination (WAW) still in flight
  assign busy = pending[raddr0] | pending[raddr1] | pending[set_addr];

endmodule

`default_nettype wire

// ==== source/stage_intf.sv ====
// Stage-to-stage interfaces of the issue subsystem
// fetch_if brings instructions in, issue_if feeds one pipe,
// complete_if carries a pipe result toward the register file
`default_nettype none

// Fetch to decode, val/rdy with held payload
interface fetch_if
  import tinyrv1_pkg::*;
();
  logic            val;
  logic            rdy;
  logic [xlen-1:0] inst;
  logic [xlen-1:0] pc;

  modport src (output val, inst, pc, input rdy);
  modport dst (input val, inst, pc, output rdy);
endinterface

// Decode to one execution pipe
interface issue_if
  import tinyrv1_pkg::*;
();
  logic                     val;
  logic                     rdy;
  rv_uop                    uop;
  logic [xlen-1:0]          op1;
  logic [xlen-1:0]          op2;
  logic [reg_addr_bits-1:0] waddr;

  modport issuer (output val, uop, op1, op2, waddr, input rdy);
  modport pipe   (input val, uop, op1, op2, waddr, output rdy);
endinterface

// Pipe result request, rdy is the grant
interface complete_if
  import tinyrv1_pkg::*;
();
  logic                     val;
  logic                     rdy;
  logic [reg_addr_bits-1:0] waddr;
  logic [xlen-1:0]          wdata;

  modport source (output val, waddr, wdata, input rdy);
  modport sink   (input val, waddr, wdata, output rdy);
endinterface

`default_nettype wire

// ==== source/tinyrv1_issue_top.sv ====
// TinyRV1 decode and issue subsystem top level
// Bridges plain fetch and writeback ports to the internal interfaces
// and connects decode, both pipes and the completion arbiter
`default_nettype none

module tinyrv1_issue_top
  import tinyrv1_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inst_val,
  output logic                     inst_rdy,
  input  logic [xlen-1:0]          inst,
  input  logic [xlen-1:0]          pc,
  output logic                     wb_val,
  output logic [reg_addr_bits-1:0] wb_waddr,
  output logic [xlen-1:0]          wb_wdata
);

  fetch_if    fetch_bus ();
  issue_if    alu_issue ();
  issue_if    mul_issue ();
  complete_if alu_done ();
  complete_if mul_done ();
  complete_if wb_bus ();

  // Fetch port
  assign fetch_bus.val  = inst_val;
  assign fetch_bus.inst = inst;
  assign fetch_bus.pc   = pc;
  assign inst_rdy       = fetch_bus.rdy;

  decode_issue_unit decode_issue_unit_inst (
    .clk   (clk),
    .rst   (rst),
    .fetch (fetch_bus),
    .alu   (alu_issue),
    .mul   (mul_issue),
    .wb    (wb_bus)
  );

  alu_pipe alu_pipe_inst (
    .clk   (clk),
    .rst   (rst),
    .issue (alu_issue),
    .done  (alu_done)
  );

  mul_pipe mul_pipe_inst (
    .clk   (clk),
    .rst   (rst),
    .issue (mul_issue),
    .done  (mul_done)
  );

  complete_arbiter complete_arbiter_inst (
    .alu_done (alu_done),
    .mul_done (mul_done),
    .wb       (wb_bus)
  );

  // Writeback port mirrors the register file write
  assign wb_val   = wb_bus.val;
  assign wb_waddr = wb_bus.waddr;
  assign wb_wdata = wb_bus.wdata;

endmodule

`default_nettype wire

// ==== source/tinyrv1_pkg.sv ====
// TinyRV1 issue subsystem package
// Opcode and micro-op encodings, instruction field positions and
// datapath sizes shared by the decoder, the pipes and the testbench model
`default_nettype none

package tinyrv1_pkg;

  // --------------------------------------------------
  // Datapath sizes
  // --------------------------------------------------

  localparam int xlen          = 32;
  localparam int half_xlen     = xlen / 2;
  localparam int reg_addr_bits = 5;
  localparam int num_regs      = 32;

  // Multiplier depth, operand capture to product
  localparam int mul_stages    = 3;

  // --------------------------------------------------
  // Instruction field positions
  // --------------------------------------------------

  localparam int opcode_lsb = 0;
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;
  localparam int imm_lsb    = 20;

  // funct3 codes used by both groups
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 codes, register-register group only
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;
  localparam logic [6:0] f7_mul  = 7'b0000001;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  typedef enum logic [6:0] {
    op_reg = 7'b0110011,
    op_imm = 7'b0010011
  } rv_opcode;

  typedef enum logic [3:0] {
    uop_add,
    uop_sub,
    uop_and,
    uop_or,
    uop_xor,
    uop_slt,
    uop_mul,
    uop_illegal
  } rv_uop;

  typedef enum logic {
    pipe_alu,
    pipe_mul
  } pipe_sel;

endpackage

`default_nettype wire

// ==== tinyrv1_issue_top.f ====
source/tinyrv1_pkg.sv
source/stage_intf.sv
source/inst_decoder.sv
source/regfile_scoreboard.sv
source/decode_issue_unit.sv
source/alu_pipe.sv
source/mul_pipe.sv
source/complete_arbiter.sv
source/tinyrv1_issue_top.sv
verification/tinyrv1_issue_assertions.sv
verification/tinyrv1_issue_tb.sv

// ==== verification/tinyrv1_issue_assertions.sv ====
// Protocol checks for the issue subsystem
// Fetch hold under back-pressure, single grant
// and a stable ALU result while it waits for the bus
`default_nettype none

module issue_protocol_checks
  import tinyrv1_pkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input logic                     fetch_val,
  input logic                     fetch_rdy,
  input logic [xlen-1:0]          fetch_inst,
  input logic [xlen-1:0]          fetch_pc,
  input logic                     alu_req,
  input logic                     alu_gnt,
  input logic [reg_addr_bits-1:0] alu_waddr,
  input logic [xlen-1:0]          alu_wdata,
  input logic                     mul_req,
  input logic                     mul_gnt
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // --------------------------------------------------
  // Completion bus
  // --------------------------------------------------

  one_grant: assert property (@(posedge clk) disable iff (rst)
    !(alu_gnt && mul_gnt))
  else begin
    fail_count++;
    $error("both pipes granted in the same cycle");
  end

  alu_hold: assert property (@(posedge clk) disable iff (rst)
    alu_req && !alu_gnt |=> alu_req && $stable(alu_wdata) && $stable(alu_waddr))
  else begin
    fail_count++;
    $error("ALU result changed while waiting for grant");
  end

  // --------------------------------------------------
  // Fetch port
  // --------------------------------------------------

  fetch_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_val && !fetch_rdy |=> fetch_val && $stable(fetch_inst) && $stable(fetch_pc))
  else begin
    fail_count++;
    $error("fetch payload dropped before transfer");
  end

endmodule

// Fetch side, arbiter group tied off
bind decode_issue_unit issue_protocol_checks fetch_checks (
  .clk        (clk),
  .rst        (rst),
  .fetch_val  (fetch.val),
  .fetch_rdy  (fetch.rdy),
  .fetch_inst (fetch.inst),
  .fetch_pc   (fetch.pc),
  .alu_req    (1'b0),
  .alu_gnt    (1'b0),
  .alu_waddr  ('0),
  .alu_wdata  ('0),
  .mul_req    (1'b0),
  .mul_gnt    (1'b0)
);

// Arbiter is purely combinational, clock taken from the top level
bind complete_arbiter issue_protocol_checks grant_checks (
  .clk        (tinyrv1_issue_top.clk),
  .rst        (tinyrv1_issue_top.rst),
  .fetch_val  (1'b0),
  .fetch_rdy  (1'b1),
  .fetch_inst ('0),
  .fetch_pc   ('0),
  .alu_req    (alu_done.val),
  .alu_gnt    (alu_grant),
  .alu_waddr  (alu_done.waddr),
  .alu_wdata  (alu_done.wdata),
  .mul_req    (mul_done.val),
  .mul_gnt    (mul_grant)
);

`default_nettype wire

// ==== verification/tinyrv1_issue_tb.sv ====
// Testbench for the TinyRV1 issue subsystem
// Table of instructions with random idle gaps, a program-order
// reference model and per-register queues of expected writebacks
`default_nettype none

module tinyrv1_issue_tb
  import tinyrv1_pkg::*;
();

  localparam int rdy_timeout   = 64;
  localparam int drain_timeout = 256;

  typedef struct {
    logic [xlen-1:0]          word;
    int                       gap;
    logic                     legal;
    logic [reg_addr_bits-1:0] rd;
    logic [xlen-1:0]          value;
  } table_row;

  logic                     clk;
  logic                     rst;
  logic                     inst_val;
  logic                     inst_rdy;
  logic [xlen-1:0]          inst;
  logic [xlen-1:0]          pc;
  logic                     wb_val;
  logic [reg_addr_bits-1:0] wb_waddr;
  logic [xlen-1:0]          wb_wdata;

  table_row                         prog [$];
  logic [xlen-1:0]                  model_regs [num_regs];
  logic [reg_addr_bits+xlen-1:0]    expect_q [num_regs][$];
  int                               pending_writes;
  logic [31:0]                      rng_state;

  tinyrv1_issue_top tinyrv1_issue_top_inst (
    .clk      (clk),
    .rst      (rst),
    .inst_val (inst_val),
    .inst_rdy (inst_rdy),
    .inst     (inst),
    .pc       (pc),
    .wb_val   (wb_val),
    .wb_waddr (wb_waddr),
    .wb_wdata (wb_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Failure reporting and compare tasks
  // --------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_wdata(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: %s data %h, expected %h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_waddr(input logic [reg_addr_bits-1:0] got,
                             input logic [reg_addr_bits-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: %s address x%0d, expected x%0d",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: %s is %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers and reference model
  // --------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // R-type word, register-register group
  function automatic logic [xlen-1:0] enc_reg(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // I-type word, register-immediate group
  function automatic logic [xlen-1:0] enc_imm(input logic [11:0] imm, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // One instruction in program order; returns 0 for an illegal encoding
  function automatic logic model_exec(input logic [xlen-1:0] word,
      output logic [reg_addr_bits-1:0] rd, output logic [xlen-1:0] value);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm;
    logic            ok;
    opc   = word[6:0];
    f3    = word[14:12];
    f7    = word[31:25];
    rd    = word[11:7];
    a     = model_regs[word[19:15]];
    b     = model_regs[word[24:20]];
    imm   = {{20{word[31]}}, word[31:20]};
    ok    = 1'b1;
    value = '0;
    if (opc == 7'b0110011 && f7 == 7'b0000000) begin
      case (f3)
        3'b000:  value = a + b;
        3'b111:  value = a & b;
        3'b110:  value = a | b;
        3'b100:  value = a ^ b;
        3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: ok = 1'b0;
      endcase
    end else if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) begin
      value = a - b;
    end else if (opc == 7'b0110011 && f7 == 7'b0000001 && f3 == 3'b000) begin
      // Low half of the product
      value = a * b;
    end else if (opc == 7'b0010011) begin
      case (f3)
        3'b000:  value = a + imm;
        3'b111:  value = a & imm;
        3'b110:  value = a | imm;
        default: ok = 1'b0;
      endcase
    end else begin
      ok = 1'b0;
    end
    // x0 stays zero, the write still shows on the port
    if (ok && rd != '0) begin
      model_regs[rd] = value;
    end
    return ok;
  endfunction

  task automatic add_row(input logic [xlen-1:0] word);
    table_row row;
    rng_state = xorshift32(rng_state);
    row.word  = word;
    row.gap   = int'(rng_state % 3);
    row.legal = model_exec(word, row.rd, row.value);
    if (row.legal) begin
      expect_q[row.rd].push_back({row.rd, row.value});
      pending_writes++;
    end
    prog.push_back(row);
  endtask

  task automatic build_table();
    // Seed registers, negative and boundary immediates
    add_row(enc_imm(12'd7,   f3_add, 5'd1, 5'd0));
    add_row(enc_imm(12'hffd, f3_add, 5'd2, 5'd0));
    add_row(enc_imm(12'd100, f3_add, 5'd3, 5'd0));
    add_row(enc_imm(12'h800, f3_add, 5'd4, 5'd0));
    add_row(enc_imm(12'h7ff, f3_or,  5'd5, 5'd0));
    // Independent ALU ops
    add_row(enc_reg(f7_base, f3_add, 5'd6,  5'd1, 5'd2));
    add_row(enc_reg(f7_sub,  f3_add, 5'd7,  5'd2, 5'd3));
    add_row(enc_reg(f7_base, f3_and, 5'd8,  5'd4, 5'd5));
    add_row(enc_reg(f7_base, f3_or,  5'd9,  5'd2, 5'd3));
    add_row(enc_reg(f7_base, f3_xor, 5'd10, 5'd1, 5'd2));
    add_row(enc_reg(f7_base, f3_slt, 5'd11, 5'd2, 5'd1));
    add_row(enc_reg(f7_base, f3_slt, 5'd12, 5'd1, 5'd2));
    add_row(enc_imm(12'hff0, f3_and, 5'd13, 5'd2));
    add_row(enc_imm(12'hf38, f3_add, 5'd14, 5'd3));
    // RAW chain through the multiplier
    add_row(enc_reg(f7_mul,  f3_add, 5'd15, 5'd1,  5'd2));
    add_row(enc_reg(f7_base, f3_add, 5'd16, 5'd15, 5'd1));
    add_row(enc_reg(f7_mul,  f3_add, 5'd17, 5'd15, 5'd4));
    // WAW on x18, mul then ALU, then a reader
    add_row(enc_reg(f7_mul,  f3_add, 5'd18, 5'd3,  5'd3));
    add_row(enc_imm(12'd1,   f3_add, 5'd18, 5'd1));
    add_row(enc_reg(f7_base, f3_add, 5'd19, 5'd18, 5'd0));
    // Mixed back-to-back traffic for arbiter contention
    add_row(enc_reg(f7_mul,  f3_add, 5'd20, 5'd2, 5'd5));
    add_row(enc_reg(f7_base, f3_add, 5'd21, 5'd1, 5'd1));
    add_row(enc_reg(f7_mul,  f3_add, 5'd22, 5'd4, 5'd4));
    add_row(enc_reg(f7_base, f3_xor, 5'd23, 5'd3, 5'd5));
    add_row(enc_reg(f7_sub,  f3_add, 5'd24, 5'd0, 5'd1));
    // x0 as destination, then as source
    add_row(enc_imm(12'd5,   f3_add, 5'd0,  5'd1));
    add_row(enc_reg(f7_base, f3_add, 5'd25, 5'd0, 5'd1));
    // Illegal encodings: load opcode, bad funct7, shift immediate
    add_row({12'd0, 5'd1, 3'b010, 5'd26, 7'b0000011});
    add_row(enc_reg(f7_sub,  f3_and, 5'd27, 5'd1, 5'd2));
    add_row(enc_imm(12'd3,   3'b001, 5'd28, 5'd1));
    // Traffic after the illegal ones
    add_row(enc_imm(12'hfff, f3_add, 5'd26, 5'd25));
    add_row(enc_reg(f7_mul,  f3_add, 5'd27, 5'd26, 5'd26));
  endtask

  // --------------------------------------------------
  // Driver and writeback monitor
  // --------------------------------------------------

  // Called on a rising edge, returns on the edge of the transfer
  task automatic send_inst(input logic [xlen-1:0] word, input logic [xlen-1:0] addr);
    int waited;
    inst_val <= 1'b1;
    inst     <= word;
    pc       <= addr;
    waited   = 0;
    @(negedge clk);
    while (!inst_rdy) begin
      waited++;
      if (waited > rdy_timeout) begin
        abort_run($sformatf("timeout waiting for inst_rdy at pc %h", addr));
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic record_writeback();
    logic [reg_addr_bits+xlen-1:0] head;
    int                            match;
    match = -1;
    if ($isunknown(wb_waddr)) begin
      abort_run("writeback address is unknown");
    end else if (expect_q[wb_waddr].size() != 0) begin
      head = expect_q[wb_waddr].pop_front();
      pending_writes--;
      check_wdata(wb_wdata, head[xlen-1:0], $sformatf("writeback x%0d", wb_waddr));
    end else begin
      // Nothing due here, look for the register this data was meant for
      for (int r = 0; r < num_regs; r++) begin
        if (match < 0 && expect_q[r].size() != 0 &&
            expect_q[r][0][xlen-1:0] === wb_wdata) begin
          match = r;
        end
      end
      if (match >= 0) begin
        check_waddr(wb_waddr, reg_addr_bits'(match), "writeback");
      end
      abort_run($sformatf("unexpected writeback to x%0d with data %h at time %0t",
                          wb_waddr, wb_wdata, $time));
    end
  endtask

  // Bus is combinational from registers, stable by the falling edge
  always @(negedge clk) begin
    if (!rst && wb_val) begin
      record_writeback();
    end
  end

  function automatic int unsigned assertion_failures();
    return tinyrv1_issue_top_inst.decode_issue_unit_inst.fetch_checks.fail_count
         + tinyrv1_issue_top_inst.complete_arbiter_inst.grant_checks.fail_count;
  endfunction

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    int waited;
    rst            = 1'b1;
    inst_val       = 1'b0;
    inst           = '0;
    pc             = '0;
    pending_writes = 0;
    rng_state      = 32'hbb87200e;
    for (int r = 0; r < num_regs; r++) begin
      model_regs[r] = '0;
    end
    build_table();

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Idle state after reset
    @(negedge clk);
    check_flag(inst_rdy, 1'b1, "inst_rdy after reset");
    check_flag(wb_val, 1'b0, "wb_val after reset");
    @(posedge clk);

    for (int i = 0; i < prog.size(); i++) begin
      if (prog[i].gap > 0) begin
        inst_val <= 1'b0;
        repeat (prog[i].gap) @(posedge clk);
      end
      send_inst(prog[i].word, 32'h0000_0200 + 4 * i);
    end
    inst_val <= 1'b0;

    // Every predicted write must show up
    waited = 0;
    while (pending_writes != 0) begin
      waited++;
      if (waited > drain_timeout) begin
        abort_run($sformatf("timeout with %0d writebacks still outstanding",
                            pending_writes));
      end
      @(posedge clk);
    end
    // Window for stray completions
    repeat (8) @(posedge clk);

    if (assertion_failures() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run($sformatf("%0d protocol assertion failures", assertion_failures()));
    end
  end

endmodule

`default_nettype wire
